//--- source/dispatch_params.svh
/*
 * Sizing macros for the dual-issue vector dispatch stage.
 * Included by the packages and by every RTL module that sizes ports or loops.
 */

`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// Micro-ops taken from the queue per cycle
`define NUM_DP_UOP 2

// Reorder buffer size, entry 0 is the oldest
`define ROB_DEPTH 8
`define ROB_INDEX_WIDTH 3

// Width of one vector register in bits
`define VLEN 32

// 32 architectural vector registers
`define VREG_INDEX_WIDTH 5

// VRF read ports shared by both slots
`define NUM_VRF_RD 4

`endif

//--- source/dispatch_uop_pkg.sv
/*
 * Types for queue micro-ops, ROB entries and the hazard search results.
 * Referenced by scoped name from the dispatch RTL.
 */

`include "dispatch_params.svh"

package dispatch_uop_pkg;

    // Target reservation station
    typedef enum logic [0:0] {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_t;

    // One micro-op as presented by the queue
    typedef struct packed {
        exe_unit_t                    exe_unit;
        logic [5:0]                   funct6;
        logic [`VREG_INDEX_WIDTH-1:0] vs1_index;
        logic                         vs1_valid;
        logic [`VREG_INDEX_WIDTH-1:0] vs2_index;
        logic                         vs2_valid;
        logic [`VREG_INDEX_WIDTH-1:0] vd_index;
        logic                         vd_valid;
        logic                         vs3_valid;  // vd is read as well
        logic                         vm;         // 0 selects the v0 mask
        logic [7:0]                   rs1_data;
    } uop_t;

    // One ROB entry as seen by dispatch
    typedef struct packed {
        logic                         valid;
        logic [`VREG_INDEX_WIDTH-1:0] w_index;
        logic                         w_valid;    // result already written back
        logic [`VLEN-1:0]             w_data;
    } rob_entry_t;

    // Search result of one source
    typedef struct packed {
        logic                        hit;
        logic                        pending;
        logic [`ROB_INDEX_WIDTH-1:0] entry;
    } src_fwd_t;

    typedef struct packed {
        src_fwd_t vs1;
        src_fwd_t vs2;
        src_fwd_t vd;
        src_fwd_t v0;
    } uop_src_fwd_t;

    typedef struct packed {
        logic [`VLEN-1:0] vs1;
        logic [`VLEN-1:0] vs2;
        logic [`VLEN-1:0] vd;
        logic [`VLEN-1:0] v0;
    } uop_operand_t;

    // VRF port number per source, element 0 is vs1, 1 is vs2, 2 is vd
    typedef logic [2:0][$clog2(`NUM_VRF_RD)-1:0] port_sel_t;

endpackage

//--- source/dispatch_rs_pkg.sv
/*
 * Payload types leaving the dispatch stage.
 * The ALU and MUL reservation stations share one payload layout.
 */

`include "dispatch_params.svh"

package dispatch_rs_pkg;

    // Reservation station entry
    typedef struct packed {
        logic [`ROB_INDEX_WIDTH-1:0] rob_entry;
        logic [5:0]                  funct6;
        logic                        vm;
        logic [`VLEN-1:0]            vs1_data;
        logic [`VLEN-1:0]            vs2_data;
        logic [`VLEN-1:0]            vd_data;
        logic [`VLEN-1:0]            v0_data;
        logic                        vs1_valid;
        logic                        vs2_valid;
        logic                        vs3_valid;
        logic [7:0]                  rs1_data;
    } rs_payload_t;

    // Allocation request to the ROB
    typedef struct packed {
        logic [`VREG_INDEX_WIDTH-1:0] w_index;
        logic                         w_valid;
    } rob_push_t;

endpackage

//--- source/dispatch_raw_check.sv
/*
 * RAW check for one dispatch slot.
 * Searches the ROB for the youngest writer of each used source and, for
 * slot 1, also checks against the destination of the older micro-op.
 */

`include "dispatch_params.svh"

module dispatch_raw_check #(
    parameter int SLOT = 0
) (
    input  dispatch_uop_pkg::uop_t                          uop,
    input  dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0]   rob_entries,
    input  dispatch_uop_pkg::uop_t                          older_uop,
    input  logic                                            older_valid,
    output dispatch_uop_pkg::uop_src_fwd_t                  src_fwd,
    output logic                                            pending
);

    localparam int IDX_W = `ROB_INDEX_WIDTH;

    logic pair_hazard;

    // Later entries overwrite earlier ones, so the youngest match decides
    function automatic dispatch_uop_pkg::src_fwd_t rob_search(
        input logic                                          used,
        input logic [`VREG_INDEX_WIDTH-1:0]                  index,
        input dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries
    );
        dispatch_uop_pkg::src_fwd_t result;
        result = '0;
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            if (used && entries[e].valid && entries[e].w_index == index) begin
                result.hit     = entries[e].w_valid;
                result.pending = !entries[e].w_valid;
                result.entry   = IDX_W'(e);
            end
        end
        return result;
    endfunction

    assign src_fwd.vs1 = rob_search(uop.vs1_valid, uop.vs1_index, rob_entries);
    assign src_fwd.vs2 = rob_search(uop.vs2_valid, uop.vs2_index, rob_entries);
    assign src_fwd.vd  = rob_search(uop.vs3_valid, uop.vd_index, rob_entries);
    // Mask always lives in v0
    assign src_fwd.v0  = rob_search(!uop.vm, '0, rob_entries);

    if (SLOT == 0) begin : gen_oldest
        assign pair_hazard = 1'b0;
    end else begin : gen_younger
        assign pair_hazard = older_valid && older_uop.vd_valid &&
            ((uop.vs1_valid && uop.vs1_index == older_uop.vd_index) ||
             (uop.vs2_valid && uop.vs2_index == older_uop.vd_index) ||
             (uop.vs3_valid && uop.vd_index  == older_uop.vd_index) ||
             (!uop.vm && older_uop.vd_index == '0));
    end

    assign pending = src_fwd.vs1.pending || src_fwd.vs2.pending ||
                     src_fwd.vd.pending  || src_fwd.v0.pending  || pair_hazard;

endmodule

//--- source/dispatch_vrf_port_alloc.sv
/*
 * VRF read port allocation for both slots.
 * Hands out ports in order (slot 0 vs1, vs2, vd, then slot 1) and flags a
 * structural hazard when the sources outnumber the read ports.
 */

`include "dispatch_params.svh"

module dispatch_vrf_port_alloc (
    input  dispatch_uop_pkg::uop_t      [`NUM_DP_UOP-1:0]        uops,
    input  logic                        [`NUM_DP_UOP-1:0]        uop_valid,
    output logic [`NUM_VRF_RD-1:0][`VREG_INDEX_WIDTH-1:0]        vrf_rd_index,
    output dispatch_uop_pkg::port_sel_t [`NUM_DP_UOP-1:0]        port_sel,
    output logic                                                 strct_hazard
);

    localparam int PORT_W = $clog2(`NUM_VRF_RD);
    localparam int CNT_W  = $clog2(3 * `NUM_DP_UOP + 1);

    logic [`NUM_DP_UOP-1:0][2:0]                         src_used;
    logic [`NUM_DP_UOP-1:0][2:0][`VREG_INDEX_WIDTH-1:0]  src_index;
    logic [CNT_W-1:0]                                    src_count;

    // Source list per slot in port order
    for (genvar s = 0; s < `NUM_DP_UOP; s++) begin : gen_src
        assign src_used[s][0]  = uop_valid[s] && uops[s].vs1_valid;
        assign src_used[s][1]  = uop_valid[s] && uops[s].vs2_valid;
        assign src_used[s][2]  = uop_valid[s] && uops[s].vs3_valid;
        assign src_index[s][0] = uops[s].vs1_index;
        assign src_index[s][1] = uops[s].vs2_index;
        assign src_index[s][2] = uops[s].vd_index;
    end

    always_comb begin
        src_count    = '0;
        vrf_rd_index = '0;
        port_sel     = '0;
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            for (int k = 0; k < 3; k++) begin
                if (src_used[s][k]) begin
                    // Sources past the last port get nothing and block the slot
                    if (src_count < CNT_W'(`NUM_VRF_RD)) begin
                        vrf_rd_index[src_count[PORT_W-1:0]] = src_index[s][k];
                        port_sel[s][k] = src_count[PORT_W-1:0];
                    end
                    src_count = src_count + 1'b1;
                end
            end
        end
    end

    assign strct_hazard = src_count > CNT_W'(`NUM_VRF_RD);

endmodule

//--- source/dispatch_operand_select.sv
/*
 * Operand gathering for one slot.
 * A source that hit a finished ROB entry takes its result data, every other
 * source reads its assigned VRF port, and the mask reads v0_data.
 */

`include "dispatch_params.svh"

module dispatch_operand_select (
    input  dispatch_uop_pkg::uop_src_fwd_t                  src_fwd,
    input  dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0]   rob_entries,
    input  logic [`NUM_VRF_RD-1:0][`VLEN-1:0]               vrf_rd_data,
    input  logic [`VLEN-1:0]                                v0_data,
    input  dispatch_uop_pkg::port_sel_t                     port_sel,
    output dispatch_uop_pkg::uop_operand_t                  operand
);

    logic [`VLEN-1:0] vs1_vrf;
    logic [`VLEN-1:0] vs2_vrf;
    logic [`VLEN-1:0] vd_vrf;

    function automatic logic [`VLEN-1:0] pick(
        input dispatch_uop_pkg::src_fwd_t                    fwd,
        input dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries,
        input logic [`VLEN-1:0]                              fallback
    );
        logic [`VLEN-1:0] data;
        data = fwd.hit ? entries[fwd.entry].w_data : fallback;
        return data;
    endfunction

    // Port data for each vector source
    assign vs1_vrf = vrf_rd_data[port_sel[0]];
    assign vs2_vrf = vrf_rd_data[port_sel[1]];
    assign vd_vrf  = vrf_rd_data[port_sel[2]];

    assign operand.vs1 = pick(src_fwd.vs1, rob_entries, vs1_vrf);
    assign operand.vs2 = pick(src_fwd.vs2, rob_entries, vs2_vrf);
    assign operand.vd  = pick(src_fwd.vd, rob_entries, vd_vrf);
    assign operand.v0  = pick(src_fwd.v0, rob_entries, v0_data);

endmodule

//--- source/dispatch_issue_ctrl.sv
/*
 * In-order issue control for the dispatch slots.
 * Combines hazards with the station and ROB readies and drives all valids
 * and readies. Nothing issues until the cycle after reset is released.
 */

`include "dispatch_params.svh"

module dispatch_issue_ctrl (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                     [`NUM_DP_UOP-1:0]   uop_valid,
    input  dispatch_uop_pkg::exe_unit_t [`NUM_DP_UOP-1:0] exe_unit,
    input  logic                     [`NUM_DP_UOP-1:0]   pending,
    input  logic                                         strct_hazard,
    input  logic                     [`NUM_DP_UOP-1:0]   alu_ready,
    input  logic                     [`NUM_DP_UOP-1:0]   mul_ready,
    input  logic                     [`NUM_DP_UOP-1:0]   rob_push_ready,
    output logic                     [`NUM_DP_UOP-1:0]   uop_ready,
    output logic                     [`NUM_DP_UOP-1:0]   alu_valid,
    output logic                     [`NUM_DP_UOP-1:0]   mul_valid,
    output logic                     [`NUM_DP_UOP-1:0]   rob_push_valid
);

    logic                   issue_enable;
    logic [`NUM_DP_UOP-1:0] unit_ready;
    logic [`NUM_DP_UOP-1:0] can_issue;
    logic [`NUM_DP_UOP-1:0] issue;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_enable <= 1'b0;
        end else begin
            issue_enable <= 1'b1;
        end
    end

    // Slot-local conditions
    for (genvar s = 0; s < `NUM_DP_UOP; s++) begin : gen_slot
        assign unit_ready[s] = (exe_unit[s] == dispatch_uop_pkg::EXE_ALU) ?
                               alu_ready[s] : mul_ready[s];
        assign can_issue[s]  = issue_enable && uop_valid[s] && !pending[s] &&
                               unit_ready[s] && rob_push_ready[s];
    end

    // A younger slot only goes when every older one goes
    always_comb begin
        issue[0] = can_issue[0];
        for (int s = 1; s < `NUM_DP_UOP; s++) begin
            issue[s] = can_issue[s] && issue[s-1] && !strct_hazard;
        end
    end

    for (genvar s = 0; s < `NUM_DP_UOP; s++) begin : gen_out
        assign alu_valid[s] = issue[s] && (exe_unit[s] == dispatch_uop_pkg::EXE_ALU);
        assign mul_valid[s] = issue[s] && (exe_unit[s] == dispatch_uop_pkg::EXE_MUL);
    end

    assign uop_ready      = issue;
    assign rob_push_valid = issue;

endmodule

//--- source/dispatch_top.sv
/*
 * Dual-issue dispatch stage for the vector back end.
 * Takes up to two in-order micro-ops per cycle, resolves RAW and VRF port
 * hazards, gathers operands and issues to the ALU or MUL station and the ROB.
 */

`include "dispatch_params.svh"

module dispatch_top (
    input  logic                                             clk,
    input  logic                                             reset,
    // Micro-op queue
    input  logic                        [`NUM_DP_UOP-1:0]    uop_valid,
    input  dispatch_uop_pkg::uop_t      [`NUM_DP_UOP-1:0]    uop,
    output logic                        [`NUM_DP_UOP-1:0]    uop_ready,
    // ALU reservation station
    output logic                        [`NUM_DP_UOP-1:0]    alu_valid,
    output dispatch_rs_pkg::rs_payload_t [`NUM_DP_UOP-1:0]   alu_rs,
    input  logic                        [`NUM_DP_UOP-1:0]    alu_ready,
    // MUL reservation station
    output logic                        [`NUM_DP_UOP-1:0]    mul_valid,
    output dispatch_rs_pkg::rs_payload_t [`NUM_DP_UOP-1:0]   mul_rs,
    input  logic                        [`NUM_DP_UOP-1:0]    mul_ready,
    // ROB push
    output logic                        [`NUM_DP_UOP-1:0]    rob_push_valid,
    output dispatch_rs_pkg::rob_push_t  [`NUM_DP_UOP-1:0]    rob_push,
    input  logic                        [`NUM_DP_UOP-1:0]    rob_push_ready,
    input  logic                        [`ROB_INDEX_WIDTH-1:0] rob_tail_index,
    input  dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0]    rob_entries,
    // VRF reads, data returns in the same cycle
    output logic [`NUM_VRF_RD-1:0][`VREG_INDEX_WIDTH-1:0]    vrf_rd_index,
    input  logic [`NUM_VRF_RD-1:0][`VLEN-1:0]                vrf_rd_data,
    input  logic [`VLEN-1:0]                                 v0_data
);

    localparam int TAG_W = `ROB_INDEX_WIDTH;

    dispatch_uop_pkg::uop_src_fwd_t [`NUM_DP_UOP-1:0] src_fwd;
    dispatch_uop_pkg::port_sel_t    [`NUM_DP_UOP-1:0] port_sel;
    dispatch_uop_pkg::uop_operand_t [`NUM_DP_UOP-1:0] operand;
    dispatch_uop_pkg::exe_unit_t    [`NUM_DP_UOP-1:0] exe_unit;
    dispatch_rs_pkg::rs_payload_t   [`NUM_DP_UOP-1:0] payload;
    logic                           [`NUM_DP_UOP-1:0] pending;
    logic                                             strct_hazard;

    // Hazard search and operand gathering per slot
    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : u_raw_check
        dispatch_raw_check #(
            .SLOT (i)
        ) i_raw_check (
            .uop         (uop[i]),
            .rob_entries (rob_entries),
            .older_uop   (uop[(i > 0) ? i - 1 : 0]),
            .older_valid (uop_valid[(i > 0) ? i - 1 : 0]),
            .src_fwd     (src_fwd[i]),
            .pending     (pending[i])
        );

        dispatch_operand_select i_operand_select (
            .src_fwd     (src_fwd[i]),
            .rob_entries (rob_entries),
            .vrf_rd_data (vrf_rd_data),
            .v0_data     (v0_data),
            .port_sel    (port_sel[i]),
            .operand     (operand[i])
        );
    end

    dispatch_vrf_port_alloc i_vrf_port_alloc (
        .uops         (uop),
        .uop_valid    (uop_valid),
        .vrf_rd_index (vrf_rd_index),
        .port_sel     (port_sel),
        .strct_hazard (strct_hazard)
    );

    dispatch_issue_ctrl i_issue_ctrl (
        .clk            (clk),
        .reset          (reset),
        .uop_valid      (uop_valid),
        .exe_unit       (exe_unit),
        .pending        (pending),
        .strct_hazard   (strct_hazard),
        .alu_ready      (alu_ready),
        .mul_ready      (mul_ready),
        .rob_push_ready (rob_push_ready),
        .uop_ready      (uop_ready),
        .alu_valid      (alu_valid),
        .mul_valid      (mul_valid),
        .rob_push_valid (rob_push_valid)
    );

    // Payload assembly, both stations see the same fields
    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_payload
        assign exe_unit[i]           = uop[i].exe_unit;
        assign payload[i].rob_entry  = rob_tail_index + TAG_W'(i);
        assign payload[i].funct6     = uop[i].funct6;
        assign payload[i].vm         = uop[i].vm;
        assign payload[i].vs1_data   = operand[i].vs1;
        assign payload[i].vs2_data   = operand[i].vs2;
        assign payload[i].vd_data    = operand[i].vd;
        assign payload[i].v0_data    = operand[i].v0;
        assign payload[i].vs1_valid  = uop[i].vs1_valid;
        assign payload[i].vs2_valid  = uop[i].vs2_valid;
        assign payload[i].vs3_valid  = uop[i].vs3_valid;
        assign payload[i].rs1_data   = uop[i].rs1_data;
        assign alu_rs[i]             = payload[i];
        assign mul_rs[i]             = payload[i];
        assign rob_push[i].w_index   = uop[i].vd_index;
        assign rob_push[i].w_valid   = uop[i].vd_valid;
    end

endmodule

//--- sim/tb_dispatch.sv
/*
 * Testbench for the dual-issue dispatch stage.
 * Runs directed hazard, forwarding and back-pressure tests, then an LFSR
 * driven random mix. A reference model is compared against the DUT each cycle.
 */

`include "dispatch_params.svh"

module tb_dispatch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 400;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;
    localparam logic [31:0] V0_CONST = 32'hA5C3_0F69;

    // Expected outputs for one cycle
    typedef struct packed {
        logic [1:0]                         ready;
        logic [1:0]                         alu_v;
        logic [1:0]                         mul_v;
        dispatch_rs_pkg::rs_payload_t [1:0] rs;
        logic [3:0][4:0]                    rd_index;
        logic [2:0]                         n_ports;
    } expect_t;

    logic clk;
    logic reset;
    logic [1:0] uop_valid;
    dispatch_uop_pkg::uop_t [1:0] uop;
    logic [1:0] uop_ready;
    logic [1:0] alu_valid;
    logic [1:0] mul_valid;
    logic [1:0] rob_push_valid;
    logic [1:0] alu_ready;
    logic [1:0] mul_ready;
    logic [1:0] rob_push_ready;
    dispatch_rs_pkg::rs_payload_t [1:0] alu_rs;
    dispatch_rs_pkg::rs_payload_t [1:0] mul_rs;
    dispatch_rs_pkg::rob_push_t [1:0] rob_push;
    logic [2:0] rob_tail_index;
    dispatch_uop_pkg::rob_entry_t [`ROB_DEPTH-1:0] rob_entries;
    logic [3:0][4:0] vrf_rd_index;
    logic [3:0][31:0] vrf_rd_data;
    logic [31:0] v0_data;
    logic exp_enable;
    logic [31:0] lfsr;
    int checks;
    int errors;
    int test_errors;
    int cycles;

    dispatch_top i_dispatch_top (
        .clk            (clk),
        .reset          (reset),
        .uop_valid      (uop_valid),
        .uop            (uop),
        .uop_ready      (uop_ready),
        .alu_valid      (alu_valid),
        .alu_rs         (alu_rs),
        .alu_ready      (alu_ready),
        .mul_valid      (mul_valid),
        .mul_rs         (mul_rs),
        .mul_ready      (mul_ready),
        .rob_push_valid (rob_push_valid),
        .rob_push       (rob_push),
        .rob_push_ready (rob_push_ready),
        .rob_tail_index (rob_tail_index),
        .rob_entries    (rob_entries),
        .vrf_rd_index   (vrf_rd_index),
        .vrf_rd_data    (vrf_rd_data),
        .v0_data        (v0_data)
    );

    always #4 clk = ~clk;

    // Issue is allowed from the first cycle that starts with reset low
    always @(posedge clk) exp_enable <= !reset;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // VRF contents depend on every bit of the register index
    function automatic logic [31:0] vrf_value(input logic [4:0] idx);
        return {idx, 3'b011, idx, 3'b110, ~idx, 3'b001, idx ^ 5'h15, 3'b100};
    endfunction

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            vrf_rd_data[p] = vrf_value(vrf_rd_index[p]);
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [159:0] exp,
                               input logic [159:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // The youngest matching entry decides
    // Returns 0 for no match, 1 for forward and 2 for pending
    function automatic int rob_lookup(input logic [4:0] idx, input logic [31:0] dflt,
                                      output logic [31:0] data);
        data = dflt;
        for (int e = `ROB_DEPTH - 1; e >= 0; e--) begin
            if (rob_entries[e].valid && rob_entries[e].w_index == idx) begin
                data = rob_entries[e].w_data;
                return rob_entries[e].w_valid ? 1 : 2;
            end
        end
        return 0;
    endfunction

    function automatic expect_t reference_model();
        expect_t x;
        dispatch_uop_pkg::uop_t u;
        logic [2:0] used;
        logic [2:0][4:0] idx;
        logic [31:0] d;
        logic [1:0] blocked;
        logic [1:0] unit_ok;
        int n;
        x = '0;
        blocked = '0;
        n = 0;
        for (int s = 0; s < 2; s++) begin
            u = uop[s];
            used = {u.vs3_valid, u.vs2_valid, u.vs1_valid};
            idx = {u.vd_index, u.vs2_index, u.vs1_index};
            for (int k = 0; k < 3; k++) begin
                if (used[k]) begin
                    if (rob_lookup(idx[k], vrf_value(idx[k]), d) == 2) blocked[s] = 1'b1;
                    if (k == 0) x.rs[s].vs1_data = d;
                    if (k == 1) x.rs[s].vs2_data = d;
                    if (k == 2) x.rs[s].vd_data = d;
                    if (s == 1 && uop_valid[0] && uop[0].vd_valid &&
                        idx[k] == uop[0].vd_index) blocked[1] = 1'b1;
                    if (uop_valid[s] && n < 4) x.rd_index[n] = idx[k];
                    if (uop_valid[s]) n++;
                end
            end
            if (!u.vm) begin
                if (rob_lookup(5'd0, V0_CONST, d) == 2) blocked[s] = 1'b1;
                x.rs[s].v0_data = d;
                if (s == 1 && uop_valid[0] && uop[0].vd_valid &&
                    uop[0].vd_index == 5'd0) blocked[1] = 1'b1;
            end
            x.rs[s].rob_entry = 3'(rob_tail_index + 3'(s));
            x.rs[s].funct6    = u.funct6;
            x.rs[s].vm        = u.vm;
            x.rs[s].vs1_valid = u.vs1_valid;
            x.rs[s].vs2_valid = u.vs2_valid;
            x.rs[s].vs3_valid = u.vs3_valid;
            x.rs[s].rs1_data  = u.rs1_data;
            unit_ok[s] = (u.exe_unit == dispatch_uop_pkg::EXE_ALU) ? alu_ready[s] : mul_ready[s];
        end
        x.ready[0] = exp_enable && uop_valid[0] && !blocked[0] && unit_ok[0] &&
                     rob_push_ready[0];
        x.ready[1] = x.ready[0] && uop_valid[1] && !blocked[1] && n <= 4 && unit_ok[1] &&
                     rob_push_ready[1];
        for (int s = 0; s < 2; s++) begin
            x.alu_v[s] = x.ready[s] && uop[s].exe_unit == dispatch_uop_pkg::EXE_ALU;
            x.mul_v[s] = x.ready[s] && uop[s].exe_unit == dispatch_uop_pkg::EXE_MUL;
        end
        x.n_ports = (n > 4) ? 3'd4 : 3'(n);
        return x;
    endfunction

    // Operand data of unused sources carries no meaning
    function automatic dispatch_rs_pkg::rs_payload_t mask_unused(
        input dispatch_rs_pkg::rs_payload_t p);
        if (!p.vs1_valid) p.vs1_data = '0;
        if (!p.vs2_valid) p.vs2_data = '0;
        if (!p.vs3_valid) p.vd_data = '0;
        if (p.vm) p.v0_data = '0;
        return p;
    endfunction

    always @(negedge clk) begin : compare
        expect_t x;
        #2;
        x = reference_model();
        check_value("uop_ready", 160'(x.ready), 160'(uop_ready));
        check_value("alu_valid", 160'(x.alu_v), 160'(alu_valid));
        check_value("mul_valid", 160'(x.mul_v), 160'(mul_valid));
        check_value("rob_push_valid", 160'(x.ready), 160'(rob_push_valid));
        for (int s = 0; s < 2; s++) begin
            if (x.alu_v[s]) check_value($sformatf("alu_rs[%0d]", s), 160'(x.rs[s]),
                                        160'(mask_unused(alu_rs[s])));
            if (x.mul_v[s]) check_value($sformatf("mul_rs[%0d]", s), 160'(x.rs[s]),
                                        160'(mask_unused(mul_rs[s])));
            if (x.ready[s]) check_value($sformatf("rob_push[%0d]", s),
                                        160'({uop[s].vd_index, uop[s].vd_valid}),
                                        160'(rob_push[s]));
        end
        for (int p = 0; p < 4; p++) begin
            if (p < int'(x.n_ports)) check_value($sformatf("vrf_rd_index[%0d]", p),
                                                 160'(x.rd_index[p]), 160'(vrf_rd_index[p]));
        end
    end

    // used holds mask, vs3, vs2, vs1 from the top bit down
    function automatic dispatch_uop_pkg::uop_t make_uop(input logic mul, input logic [3:0] used,
        input logic [4:0] vs1, input logic [4:0] vs2, input logic [4:0] vd);
        dispatch_uop_pkg::uop_t u;
        u.exe_unit  = mul ? dispatch_uop_pkg::EXE_MUL : dispatch_uop_pkg::EXE_ALU;
        u.funct6    = 6'(rand_bits(6));
        u.vs1_index = vs1;
        u.vs1_valid = used[0];
        u.vs2_index = vs2;
        u.vs2_valid = used[1];
        u.vd_index  = vd;
        u.vd_valid  = 1'b1;
        u.vs3_valid = used[2];
        u.vm        = !used[3];
        u.rs1_data  = 8'(rand_bits(8));
        return u;
    endfunction

    function automatic dispatch_uop_pkg::uop_t random_uop();
        dispatch_uop_pkg::uop_t u;
        u = make_uop(1'(rand_bits(1)), 4'(rand_bits(4)), 5'(rand_bits(3)), 5'(rand_bits(3)),
                     5'(rand_bits(3)));
        u.vd_valid = 1'(rand_bits(1));
        return u;
    endfunction

    function automatic dispatch_uop_pkg::rob_entry_t make_rob_entry(input logic [4:0] idx,
        input logic done, input logic [31:0] data);
        return '{valid: 1'b1, w_index: idx, w_valid: done, w_data: data};
    endfunction

    task automatic randomize_inputs();
        uop_valid      = 2'(rand_bits(2));
        alu_ready      = 2'(rand_bits(2) | rand_bits(2));
        mul_ready      = 2'(rand_bits(2) | rand_bits(2));
        rob_push_ready = 2'(rand_bits(2) | rand_bits(2));
        rob_tail_index = 3'(rand_bits(3));
        for (int s = 0; s < 2; s++) uop[s] = random_uop();
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            rob_entries[e] = make_rob_entry(5'(rand_bits(3)), 1'(rand_bits(1)), rand_bits(32));
            rob_entries[e].valid = &2'(rand_bits(2));
        end
    endtask

    // Checks the intended issue pattern, then moves to the next falling edge
    task automatic step(input logic [1:0] want);
        #1;
        check_value("uop_ready", 160'(want), 160'(uop_ready));
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        #3;
        $display("Test %-16s %s, %0d mismatches", name,
                 (errors == test_errors) ? "passed" : "failed", errors - test_errors);
        test_errors = errors;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lfsr = 32'd76047;
        checks = 0;
        errors = 0;
        test_errors = 0;
        cycles = 0;
        exp_enable = 1'b0;
        v0_data = V0_CONST;
        alu_ready = 2'b11;
        mul_ready = 2'b11;
        rob_push_ready = 2'b11;
        rob_tail_index = 3'd0;
        rob_entries = '0;
        uop_valid = 2'b11;
        uop[0] = make_uop(1'b0, 4'b0011, 5'd1, 5'd2, 5'd3);
        uop[1] = make_uop(1'b1, 4'b0001, 5'd4, 5'd0, 5'd5);

        // Reset release followed by an independent pair with tags tail and tail+1
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        step(2'b00);
        rob_tail_index = 3'd7;
        step(2'b11);
        finish_test("reset");

        // Younger of two finished writers supplies the data
        rob_entries[2] = make_rob_entry(5'd1, 1'b1, 32'h1111_2222);
        rob_entries[6] = make_rob_entry(5'd1, 1'b1, 32'h3333_4444);
        rob_entries[3] = make_rob_entry(5'd7, 1'b1, 32'h5555_6666);
        uop[0] = make_uop(1'b0, 4'b0001, 5'd1, 5'd0, 5'd10);
        uop[1] = make_uop(1'b1, 4'b0010, 5'd0, 5'd7, 5'd11);
        #1;
        check_value("alu_rs[0].vs1_data", 160'(32'h3333_4444), 160'(alu_rs[0].vs1_data));
        step(2'b11);
        finish_test("rob_forward");

        rob_entries = '0;
        rob_entries[4] = make_rob_entry(5'd2, 1'b0, 32'h7777_8888);
        uop[0] = make_uop(1'b0, 4'b0011, 5'd1, 5'd2, 5'd12);
        step(2'b00);
        uop[0] = make_uop(1'b0, 4'b0001, 5'd1, 5'd0, 5'd12);
        uop[1] = make_uop(1'b1, 4'b0001, 5'd2, 5'd0, 5'd13);
        step(2'b01);
        finish_test("rob_pending");

        // Slot 1 reads the destination of slot 0, also through the mask
        rob_entries = '0;
        uop[0] = make_uop(1'b0, 4'b0001, 5'd1, 5'd0, 5'd9);
        uop[1] = make_uop(1'b1, 4'b0001, 5'd9, 5'd0, 5'd14);
        step(2'b01);
        uop[0] = make_uop(1'b1, 4'b0001, 5'd1, 5'd0, 5'd0);
        uop[1] = make_uop(1'b0, 4'b1000, 5'd0, 5'd0, 5'd15);
        step(2'b01);
        finish_test("pair_hazard");

        uop[0] = make_uop(1'b0, 4'b0111, 5'd1, 5'd2, 5'd3);
        uop[1] = make_uop(1'b1, 4'b0011, 5'd4, 5'd5, 5'd6);
        step(2'b01);
        uop[1] = make_uop(1'b1, 4'b0001, 5'd4, 5'd0, 5'd6);
        #1;
        check_value("vrf_rd_index", 160'({5'd4, 5'd3, 5'd2, 5'd1}), 160'(vrf_rd_index));
        step(2'b11);
        finish_test("read_ports");

        // ALU slot 0 and MUL slot 1 under dropped readies
        uop[0] = make_uop(1'b0, 4'b0001, 5'd1, 5'd0, 5'd3);
        uop[1] = make_uop(1'b1, 4'b0001, 5'd2, 5'd0, 5'd4);
        alu_ready = 2'b10;
        step(2'b00);
        alu_ready = 2'b11;
        mul_ready = 2'b01;
        step(2'b01);
        mul_ready = 2'b11;
        rob_push_ready = 2'b10;
        step(2'b00);
        rob_push_ready = 2'b01;
        step(2'b01);
        rob_push_ready = 2'b11;
        finish_test("backpressure");

        repeat (RANDOM_CYCLES) begin
            randomize_inputs();
            @(negedge clk);
        end
        finish_test("random_mix");

        $display("Summary: %0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/dispatch_uop_pkg.sv
source/dispatch_rs_pkg.sv
source/dispatch_raw_check.sv
source/dispatch_vrf_port_alloc.sv
source/dispatch_operand_select.sv
source/dispatch_issue_ctrl.sv
source/dispatch_top.sv
sim/tb_dispatch.sv

//--- Makefile
# Verilator build for the dispatch stage

VERILATOR  ?= verilator
TB_TOP     := tb_dispatch
RTL_TOP    := dispatch_top
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
